/* run.sh */
#!/usr/bin/env bash
# build and run the ixu_cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module ixu_cluster_tb -f sim.f -o Vixu_cluster_tb

# the simulation may stop on an assertion, the log decides
./obj_dir/Vixu_cluster_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* sim.f */
verilog/ixu_isa_pkg.sv
verilog/ixu_pipe_pkg.sv
verilog/int_regfile.sv
verilog/ixu_dispatch.sv
verilog/ixu_alu_pipe.sv
verilog/radix2_divider.sv
verilog/ixu_mc_pipe.sv
verilog/wb_arbiter.sv
verilog/ixu_cluster.sv
sim/ixu_cluster_assert.sv
sim/ixu_cluster_tb.sv

/* sim/ixu_cluster_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module ixu_cluster_assert
  import ixu_isa_pkg::*;
  import ixu_pipe_pkg::*;
#(
  parameter int DIV_STEPS = 32
) (
  input wire              core_clock_i,
  input wire              rst_i,
  input wire              core_flush_i,
  input wire ixu_issue_t  issue_i,
  input wire              issue_valid_i,
  input wire              issue_ready_o,
  input wire ixu_result_t cmp_o,
  input wire              cmp_valid_o,
  input wire              cmp_ready_i,
  input wire              mc_ready_i,
  input wire              mc_res_valid_i
);

  logic [31:0] pend_q;
  logic        seen_issue_q;
  int          div_cnt_q;
  logic        issue_fire;

  assign issue_fire = issue_valid_i && issue_ready_o;

  always_ff @(posedge core_clock_i) begin
    if (rst_i) seen_issue_q <= 1'b0;
    else if (issue_fire) seen_issue_q <= 1'b1;
    if (rst_i || core_flush_i) begin
      pend_q    <= '0;
      div_cnt_q <= 0;
    end else begin
      if (cmp_valid_o && cmp_ready_i) pend_q[cmp_o.rd] <= 1'b0;
      if (issue_fire && (issue_i.rd != '0)) pend_q[issue_i.rd] <= 1'b1;
      if (issue_fire && (issue_i.op_class == CLASS_DIV)) div_cnt_q <= DIV_STEPS;
      else if (div_cnt_q != 0) div_cnt_q <= div_cnt_q - 1;
    end
  end

  // a stalled result only gives way to a multi-cycle result that just arrived
  stalled_stable: assert property (@(posedge core_clock_i) disable iff (rst_i || core_flush_i)
    cmp_valid_o && !cmp_ready_i |=> cmp_valid_o && ($stable(cmp_o) || $rose(mc_res_valid_i)))
    else $error("completion payload changed while stalled");

  no_early_cmp: assert property (@(posedge core_clock_i) disable iff (rst_i)
    !seen_issue_q |-> !cmp_valid_o)
    else $error("completion before any issue");

  rd_pending_blocks: assert property (@(posedge core_clock_i) disable iff (rst_i)
    pend_q[issue_i.rd] |-> !issue_ready_o)
    else $error("issue ready while rd is pending");

  div_holds_mc: assert property (@(posedge core_clock_i) disable iff (rst_i || core_flush_i)
    (div_cnt_q != 0) |-> !mc_ready_i)
    else $error("multi-cycle pipe ready during a divide");

endmodule

bind ixu_cluster ixu_cluster_assert #(
  .DIV_STEPS(DIV_STEPS)
) u_assert (
  .core_clock_i  (core_clock_i),
  .rst_i         (rst_i),
  .core_flush_i  (core_flush_i),
  .issue_i       (issue_i),
  .issue_valid_i (issue_valid_i),
  .issue_ready_o (issue_ready_o),
  .cmp_o         (cmp_o),
  .cmp_valid_o   (cmp_valid_o),
  .cmp_ready_i   (cmp_ready_i),
  .mc_ready_i    (mc_ready),
  .mc_res_valid_i(mc_res_valid)
);

`default_nettype wire

/* sim/ixu_cluster_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ixu_cluster_tb
  import ixu_isa_pkg::*;
  import ixu_pipe_pkg::*;
;

  localparam int DIV_STEPS = 32;
  localparam int TOTAL_OPS = 700;

  logic        core_clock_i;
  logic        rst_i;
  logic        core_flush_i;
  ixu_issue_t  issue_i;
  logic        issue_valid_i;
  logic        issue_ready_o;
  ixu_result_t cmp_o;
  logic        cmp_valid_o;
  logic        cmp_ready_i;

  // reference model state
  xlen_data_t  model_regs [32];
  logic [31:0] pend;
  ixu_result_t exp_by_tag [32];
  logic        outstanding [32];
  int          issue_cyc [32];
  int          min_lat [32];
  int          free_tags [$];
  ixu_issue_t  uop_q [$];
  int          n_out;
  int          cycle;
  int          errors;
  int          checks;
  int          stall_pct;
  logic        hold_cmp;
  logic        issue_fired;
  logic        check_first_ready;
  logic        hazard_mode;
  logic        hazard_div_seen;
  int          hazard_div_tag;
  int          alu_before_div;

  ixu_cluster #(
    .DIV_STEPS(DIV_STEPS)
  ) u_ixu_cluster (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .core_flush_i (core_flush_i),
    .issue_i      (issue_i),
    .issue_valid_i(issue_valid_i),
    .issue_ready_o(issue_ready_o),
    .cmp_o        (cmp_o),
    .cmp_valid_o  (cmp_valid_o),
    .cmp_ready_i  (cmp_ready_i)
  );

  initial begin
    core_clock_i = 1'b0;
    forever #5 core_clock_i = ~core_clock_i;
  end

  initial begin
    #(TOTAL_OPS * (DIV_STEPS + 10) * 10);
    $display("timeout: the run did not finish in time, the DUT stopped completing");
    $display("TB FAILED");
    $finish;
  end

  task automatic check_result(input ixu_result_t got, input ixu_result_t exp_res,
                              input string what);
    checks++;
    if (got !== exp_res) begin
      errors++;
      $display("[FAIL] %0t %s: got rd=%0d data=%h tag=%0d, expected rd=%0d data=%h tag=%0d",
               $time, what, got.rd, got.data, got.rob_tag,
               exp_res.rd, exp_res.data, exp_res.rob_tag);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp_val, input string what);
    checks++;
    if (got !== exp_val) begin
      errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp_val);
    end
  endtask

  function automatic xlen_data_t model_value(ixu_op_t op, xlen_data_t a, xlen_data_t b);
    logic [63:0] prod;
    logic        ovf;
    xlen_data_t  r;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SLL:  r = a << b[4:0];
      OP_SRL:  r = a >> b[4:0];
      OP_SRA:  r = xlen_data_t'($signed(a) >>> b[4:0]);
      OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      OP_MUL, OP_MULH: begin
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        r = (op == OP_MUL) ? prod[31:0] : prod[63:32];
      end
      OP_MULHU: begin
        prod = {32'd0, a} * {32'd0, b};
        r = prod[63:32];
      end
      OP_DIV:  r = (b == 0) ? '1 : ovf ? a : xlen_data_t'($signed(a) / $signed(b));
      OP_DIVU: r = (b == 0) ? '1 : a / b;
      OP_REM:  r = (b == 0) ? a : ovf ? '0 : xlen_data_t'($signed(a) % $signed(b));
      OP_REMU: r = (b == 0) ? a : a % b;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic ixu_issue_t build_uop(ixu_op_t op, int rd, int rs1, int rs2,
                                           logic use_imm, xlen_data_t imm);
    ixu_issue_t u;
    u.op       = op;
    u.op_class = (op <= OP_SLTU) ? CLASS_ALU : (op <= OP_MULHU) ? CLASS_MUL : CLASS_DIV;
    u.rd       = reg_idx_t'(rd);
    u.rs1      = reg_idx_t'(rs1);
    u.rs2      = reg_idx_t'(rs2);
    u.use_imm  = use_imm;
    u.imm      = imm;
    u.rob_tag  = '0;
    return u;
  endfunction

  // kind picks ALU (0), MUL (1), DIV (2) or a mix of all ops
  function automatic ixu_issue_t random_uop(int kind);
    int n;
    case (kind)
      0: n = $urandom % 10;
      1: n = 10 + $urandom % 3;
      2: n = 13 + $urandom % 4;
      default: n = $urandom % 17;
    endcase
    return build_uop(ixu_op_t'(n), $urandom % 32, $urandom % 32, $urandom % 32,
                     ($urandom % 4) == 0, (($urandom % 8) == 0) ? '0 : $urandom);
  endfunction

  task automatic observe_cycle();
    ixu_result_t exp_res;
    int          tag;
    logic        lat_ok;
    @(negedge core_clock_i);
    issue_fired = 1'b0;
    if (issue_valid_i && (pend[issue_i.rs1] || pend[issue_i.rs2] || pend[issue_i.rd])) begin
      check_ready(issue_ready_o, 1'b0, "issue ready with a pending register");
    end
    if (check_first_ready && issue_valid_i) begin
      check_ready(issue_ready_o, 1'b1, "issue ready right after flush");
      check_first_ready = 1'b0;
    end
    if (cmp_valid_o && cmp_ready_i) begin
      tag = cmp_o.rob_tag;
      if (!outstanding[tag]) begin
        errors++;
        $display("[FAIL] %0t completion for tag %0d which is not in flight", $time, tag);
      end else begin
        check_result(cmp_o, exp_by_tag[tag], "completion");
        lat_ok = (cycle - issue_cyc[tag]) >= min_lat[tag];
        check_ready(lat_ok, 1'b1, "completion no earlier than the pipe latency");
        if (exp_by_tag[tag].rd != 0) model_regs[exp_by_tag[tag].rd] = exp_by_tag[tag].data;
        pend[exp_by_tag[tag].rd] = 1'b0;
        outstanding[tag] = 1'b0;
        n_out--;
        free_tags.push_back(tag);
        if (hazard_mode) begin
          if (tag == hazard_div_tag) hazard_div_seen = 1'b1;
          else if (!hazard_div_seen) alu_before_div++;
        end
      end
    end
    if (issue_valid_i && issue_ready_o) begin
      tag = issue_i.rob_tag;
      exp_res.rd      = issue_i.rd;
      exp_res.rob_tag = issue_i.rob_tag;
      exp_res.data    = model_value(issue_i.op, model_regs[issue_i.rs1],
                                    issue_i.use_imm ? issue_i.imm : model_regs[issue_i.rs2]);
      exp_by_tag[tag]  = exp_res;
      outstanding[tag] = 1'b1;
      issue_cyc[tag]   = cycle;
      min_lat[tag]     = (issue_i.op_class == CLASS_ALU) ? 1 :
                         (issue_i.op_class == CLASS_MUL) ? 2 : DIV_STEPS + 1;
      n_out++;
      if (issue_i.rd != 0) pend[issue_i.rd] = 1'b1;
      if (hazard_mode && (issue_i.op_class == CLASS_DIV)) hazard_div_tag = tag;
      issue_fired = 1'b1;
    end
  endtask

  task automatic drive_cycle();
    ixu_issue_t u;
    @(posedge core_clock_i);
    cycle++;
    #1;
    if (issue_fired) issue_valid_i = 1'b0;
    if (!issue_valid_i && (uop_q.size() > 0) && (free_tags.size() > 0) &&
        (($urandom % 100) < 85)) begin
      u = uop_q.pop_front();
      u.rob_tag = rob_tag_t'(free_tags.pop_front());
      issue_i = u;
      issue_valid_i = 1'b1;
    end
    cmp_ready_i = hold_cmp ? 1'b0 : (($urandom % 100) >= stall_pct);
  endtask

  task automatic run_test(input string name);
    int e0;
    e0 = errors;
    while ((uop_q.size() > 0) || issue_valid_i || (n_out > 0)) begin
      observe_cycle();
      drive_cycle();
    end
    $display("test %-9s done, %0d errors", name, errors - e0);
  endtask

  task automatic queue_readback();
    for (int r = 0; r < 32; r++) uop_q.push_back(build_uop(OP_ADD, 0, r, 0, 1'b0, '0));
  endtask

  task automatic flush_now();
    core_flush_i = 1'b1;
    cmp_ready_i  = 1'b0;
    observe_cycle();
    @(posedge core_clock_i);
    cycle++;
    #1;
    core_flush_i = 1'b0;
    // everything in flight is dropped and its tags go back to the free list
    for (int t = 0; t < 32; t++) begin
      if (outstanding[t]) free_tags.push_back(t);
      outstanding[t] = 1'b0;
    end
    if (issue_valid_i) free_tags.push_back(issue_i.rob_tag);
    issue_valid_i = 1'b0;
    n_out = 0;
    pend = '0;
    uop_q.delete();
  endtask

  initial begin
    void'($urandom(32'he4afbafe));
    rst_i = 1'b1;
    core_flush_i = 1'b0;
    issue_i = '0;
    issue_valid_i = 1'b0;
    cmp_ready_i = 1'b0;
    pend = '0;
    n_out = 0;
    cycle = 0;
    errors = 0;
    checks = 0;
    stall_pct = 10;
    hold_cmp = 1'b0;
    issue_fired = 1'b0;
    check_first_ready = 1'b0;
    hazard_mode = 1'b0;
    hazard_div_seen = 1'b0;
    hazard_div_tag = -1;
    alu_before_div = 0;
    for (int t = 0; t < 32; t++) begin
      model_regs[t] = '0;
      outstanding[t] = 1'b0;
      free_tags.push_back(t);
    end
    repeat (4) @(posedge core_clock_i);
    #1;
    rst_i = 1'b0;

    for (int r = 1; r < 32; r++) uop_q.push_back(build_uop(OP_ADD, r, 0, 0, 1'b1, $urandom));
    run_test("init");
    for (int i = 0; i < 150; i++) uop_q.push_back(random_uop(0));
    run_test("alu");
    for (int i = 0; i < 80; i++) uop_q.push_back(random_uop(1));
    run_test("mul");

    // overflow and divide by zero cases come before the random divides
    uop_q.push_back(build_uop(OP_ADD, 1, 0, 0, 1'b1, 32'h8000_0000));
    uop_q.push_back(build_uop(OP_ADD, 2, 0, 0, 1'b1, 32'hffff_ffff));
    uop_q.push_back(build_uop(OP_DIV, 3, 1, 2, 1'b0, '0));
    uop_q.push_back(build_uop(OP_REM, 4, 1, 2, 1'b0, '0));
    uop_q.push_back(build_uop(OP_DIVU, 5, 1, 0, 1'b0, '0));
    uop_q.push_back(build_uop(OP_REM, 6, 1, 0, 1'b0, '0));
    for (int i = 0; i < 60; i++) uop_q.push_back(random_uop(2));
    run_test("div");

    stall_pct = 0;
    hazard_mode = 1'b1;
    uop_q.push_back(build_uop(OP_DIV, 5, 3, 4, 1'b0, '0));
    uop_q.push_back(build_uop(OP_ADD, 10, 1, 2, 1'b0, '0));
    uop_q.push_back(build_uop(OP_XOR, 11, 3, 4, 1'b0, '0));
    uop_q.push_back(build_uop(OP_OR, 12, 1, 3, 1'b0, '0));
    uop_q.push_back(build_uop(OP_ADD, 6, 5, 0, 1'b1, 32'd7));
    uop_q.push_back(build_uop(OP_SUB, 5, 5, 1, 1'b0, '0));
    run_test("hazard");
    check_ready(alu_before_div == 3, 1'b1, "independent ALU ops finish before the divide");
    hazard_mode = 1'b0;

    stall_pct = 30;
    for (int i = 0; i < 250; i++) uop_q.push_back(random_uop(3));
    queue_readback();
    run_test("stall");

    stall_pct = 10;
    hold_cmp = 1'b1;
    uop_q.push_back(build_uop(OP_DIV, 7, 3, 4, 1'b0, '0));
    uop_q.push_back(build_uop(OP_ADD, 8, 1, 2, 1'b1, 32'h55));
    uop_q.push_back(build_uop(OP_ADD, 9, 3, 0, 1'b1, 32'h66));
    while (n_out < 2) begin
      observe_cycle();
      drive_cycle();
    end
    repeat (5) begin
      observe_cycle();
      drive_cycle();
    end
    flush_now();
    hold_cmp = 1'b0;
    check_first_ready = 1'b1;
    // first op after the flush reads the registers of both dropped results
    uop_q.push_back(build_uop(OP_ADD, 0, 7, 8, 1'b0, '0));
    queue_readback();
    run_test("flush");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/int_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module int_regfile
  import ixu_pipe_pkg::*;
(
  input  wire             core_clock_i,
  input  wire reg_idx_t   rs1_idx_i,
  input  wire reg_idx_t   rs2_idx_i,
  output xlen_data_t      rs1_data_o,
  output xlen_data_t      rs2_data_o,
  input  wire             wr_en_i,
  input  wire reg_idx_t   wr_idx_i,
  input  wire xlen_data_t wr_data_i
);

  xlen_data_t regs [32];

  // x0 is never stored, it is forced on the read side
  always_ff @(posedge core_clock_i) begin
    if (wr_en_i && (wr_idx_i != '0)) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // reads see the old value in a write cycle
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

`default_nettype wire

/* verilog/ixu_alu_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module ixu_alu_pipe
  import ixu_isa_pkg::*;
  import ixu_pipe_pkg::*;
(
  input  wire            core_clock_i,
  input  wire            rst_i,
  input  wire            core_flush_i,
  input  wire ixu_exec_t req_i,
  input  wire            req_valid_i,
  output logic           req_ready_o,
  output ixu_result_t    res_o,
  output logic           res_valid_o,
  input  wire            res_ready_i
);

  xlen_data_t  alu_result;
  logic [4:0]  shamt;
  ixu_result_t res_q;
  logic        res_valid_q;

  assign shamt = req_i.b[4:0];

  always_comb begin
    case (req_i.op)
      OP_ADD:  alu_result = req_i.a + req_i.b;
      OP_SUB:  alu_result = req_i.a - req_i.b;
      OP_AND:  alu_result = req_i.a & req_i.b;
      OP_OR:   alu_result = req_i.a | req_i.b;
      OP_XOR:  alu_result = req_i.a ^ req_i.b;
      OP_SLL:  alu_result = req_i.a << shamt;
      OP_SRL:  alu_result = req_i.a >> shamt;
      OP_SRA:  alu_result = $signed(req_i.a) >>> shamt;
      OP_SLT:  alu_result = {31'd0, $signed(req_i.a) < $signed(req_i.b)};
      OP_SLTU: alu_result = {31'd0, req_i.a < req_i.b};
      default: alu_result = '0;
    endcase
  end

  // the slot frees up in the same cycle its result is taken
  assign req_ready_o = !res_valid_q || res_ready_i;

  always_ff @(posedge core_clock_i) begin
    if (rst_i || core_flush_i) begin
      res_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      res_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (req_valid_i && req_ready_o) begin
      res_q <= '{rd: req_i.rd, data: alu_result, rob_tag: req_i.rob_tag};
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

/* verilog/ixu_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module ixu_cluster
  import ixu_pipe_pkg::*;
#(
  parameter int DIV_STEPS = 32
) (
  input  wire              core_clock_i,
  input  wire              rst_i,
  input  wire              core_flush_i,
  input  wire ixu_issue_t  issue_i,
  input  wire              issue_valid_i,
  output logic             issue_ready_o,
  output ixu_result_t      cmp_o,
  output logic             cmp_valid_o,
  input  wire              cmp_ready_i
);

  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  xlen_data_t  rs1_data;
  xlen_data_t  rs2_data;
  ixu_exec_t   alu_req;
  ixu_exec_t   mc_req;
  logic        alu_valid;
  logic        mc_valid;
  logic        alu_ready;
  logic        mc_ready;
  ixu_result_t alu_res;
  ixu_result_t mc_res;
  logic        alu_res_valid;
  logic        mc_res_valid;
  logic        alu_res_ready;
  logic        mc_res_ready;
  logic        wr_en;
  logic        clr_en;
  reg_idx_t    clr_idx;

  ixu_dispatch u_dispatch (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .core_flush_i (core_flush_i),
    .issue_i      (issue_i),
    .issue_valid_i(issue_valid_i),
    .issue_ready_o(issue_ready_o),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .alu_req_o    (alu_req),
    .mc_req_o     (mc_req),
    .alu_valid_o  (alu_valid),
    .mc_valid_o   (mc_valid),
    .alu_ready_i  (alu_ready),
    .mc_ready_i   (mc_ready),
    .clr_en_i     (clr_en),
    .clr_idx_i    (clr_idx)
  );

  // written only from the completion bus
  int_regfile u_regfile (
    .core_clock_i(core_clock_i),
    .rs1_idx_i   (rs1_idx),
    .rs2_idx_i   (rs2_idx),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .wr_en_i     (wr_en),
    .wr_idx_i    (cmp_o.rd),
    .wr_data_i   (cmp_o.data)
  );

  ixu_alu_pipe u_alu_pipe (
    .core_clock_i(core_clock_i),
    .rst_i       (rst_i),
    .core_flush_i(core_flush_i),
    .req_i       (alu_req),
    .req_valid_i (alu_valid),
    .req_ready_o (alu_ready),
    .res_o       (alu_res),
    .res_valid_o (alu_res_valid),
    .res_ready_i (alu_res_ready)
  );

  ixu_mc_pipe #(
    .DIV_STEPS(DIV_STEPS)
  ) u_mc_pipe (
    .core_clock_i(core_clock_i),
    .rst_i       (rst_i),
    .core_flush_i(core_flush_i),
    .req_i       (mc_req),
    .req_valid_i (mc_valid),
    .req_ready_o (mc_ready),
    .res_o       (mc_res),
    .res_valid_o (mc_res_valid),
    .res_ready_i (mc_res_ready)
  );

  wb_arbiter u_wb_arbiter (
    .mc_res_i   (mc_res),
    .alu_res_i  (alu_res),
    .mc_valid_i (mc_res_valid),
    .alu_valid_i(alu_res_valid),
    .mc_ready_o (mc_res_ready),
    .alu_ready_o(alu_res_ready),
    .cmp_o      (cmp_o),
    .cmp_valid_o(cmp_valid_o),
    .cmp_ready_i(cmp_ready_i),
    .wr_en_o    (wr_en),
    .clr_en_o   (clr_en),
    .clr_idx_o  (clr_idx)
  );

endmodule

`default_nettype wire

/* verilog/ixu_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module ixu_dispatch
  import ixu_isa_pkg::*;
  import ixu_pipe_pkg::*;
(
  input  wire             core_clock_i,
  input  wire             rst_i,
  input  wire             core_flush_i,
  input  wire ixu_issue_t issue_i,
  input  wire             issue_valid_i,
  output logic            issue_ready_o,
  output reg_idx_t        rs1_idx_o,
  output reg_idx_t        rs2_idx_o,
  input  wire xlen_data_t rs1_data_i,
  input  wire xlen_data_t rs2_data_i,
  output ixu_exec_t       alu_req_o,
  output ixu_exec_t       mc_req_o,
  output logic            alu_valid_o,
  output logic            mc_valid_o,
  input  wire             alu_ready_i,
  input  wire             mc_ready_i,
  input  wire             clr_en_i,
  input  wire reg_idx_t   clr_idx_i
);

  logic [31:0] pending_q;
  logic        to_alu;
  logic        target_ready;
  logic        hazard;
  logic        can_go;
  logic        issue_fire;
  ixu_exec_t   exec_req;

  assign to_alu       = (issue_i.op_class == CLASS_ALU);
  assign target_ready = to_alu ? alu_ready_i : mc_ready_i;
  assign hazard       = pending_q[issue_i.rs1] || pending_q[issue_i.rs2] ||
                        pending_q[issue_i.rd];
  // nothing leaves dispatch in a flush cycle
  assign can_go       = !hazard && !core_flush_i;

  assign issue_ready_o = target_ready && can_go;
  assign issue_fire    = issue_valid_i && issue_ready_o;
  assign alu_valid_o   = issue_valid_i && to_alu && can_go;
  assign mc_valid_o    = issue_valid_i && !to_alu && can_go;

  assign rs1_idx_o = issue_i.rs1;
  assign rs2_idx_o = issue_i.rs2;

  always_comb begin
    exec_req.op      = issue_i.op;
    exec_req.a       = rs1_data_i;
    exec_req.b       = issue_i.use_imm ? issue_i.imm : rs2_data_i;
    exec_req.rd      = issue_i.rd;
    exec_req.rob_tag = issue_i.rob_tag;
  end

  assign alu_req_o = exec_req;
  assign mc_req_o  = exec_req;

  always_ff @(posedge core_clock_i) begin
    if (rst_i || core_flush_i) begin
      pending_q <= '0;
    end else begin
      if (clr_en_i) pending_q[clr_idx_i] <= 1'b0;
      // set comes last so it wins over a clear of the same register
      if (issue_fire && (issue_i.rd != '0)) pending_q[issue_i.rd] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/ixu_isa_pkg.sv */
`default_nettype none

package ixu_isa_pkg;

  // which pipe a micro-op goes to
  typedef enum logic [1:0] {
    CLASS_ALU = 2'd0,
    CLASS_MUL = 2'd1,
    CLASS_DIV = 2'd2
  } ixu_op_class_t;

  // ops up to SLTU run in the ALU pipe, the rest in the multi-cycle pipe
  typedef enum logic [4:0] {
    OP_ADD   = 5'd0,
    OP_SUB   = 5'd1,
    OP_AND   = 5'd2,
    OP_OR    = 5'd3,
    OP_XOR   = 5'd4,
    OP_SLL   = 5'd5,
    OP_SRL   = 5'd6,
    OP_SRA   = 5'd7,
    OP_SLT   = 5'd8,
    OP_SLTU  = 5'd9,
    OP_MUL   = 5'd10,
    OP_MULH  = 5'd11,
    OP_MULHU = 5'd12,
    OP_DIV   = 5'd13,
    OP_DIVU  = 5'd14,
    OP_REM   = 5'd15,
    OP_REMU  = 5'd16
  } ixu_op_t;

endpackage

`default_nettype wire

/* verilog/ixu_mc_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module ixu_mc_pipe
  import ixu_isa_pkg::*;
  import ixu_pipe_pkg::*;
#(
  parameter int DIV_STEPS = 32
) (
  input  wire            core_clock_i,
  input  wire            rst_i,
  input  wire            core_flush_i,
  input  wire ixu_exec_t req_i,
  input  wire            req_valid_i,
  output logic           req_ready_o,
  output ixu_result_t    res_o,
  output logic           res_valid_o,
  input  wire            res_ready_i
);

  typedef enum logic [1:0] {
    IDLE,
    MULTIPLY,
    DIVIDE,
    HOLD
  } mc_state_t;

  mc_state_t          state_q;
  ixu_op_t            op_q;
  xlen_data_t         a_q;
  xlen_data_t         b_q;
  reg_idx_t           rd_q;
  rob_tag_t           rob_tag_q;
  xlen_data_t         data_q;
  logic               req_fire;
  logic               req_is_div;
  logic signed [32:0] mul_a;
  logic signed [32:0] mul_b;
  logic signed [65:0] product;
  xlen_data_t         mul_word;
  logic               div_done;
  xlen_data_t         div_res;

  // one micro-op at a time, the next may enter as the held result leaves
  assign req_ready_o = (state_q == IDLE) || ((state_q == HOLD) && res_ready_i);
  assign req_fire    = req_valid_i && req_ready_o;
  assign req_is_div  = (req_i.op == OP_DIV) || (req_i.op == OP_DIVU) ||
                       (req_i.op == OP_REM) || (req_i.op == OP_REMU);

  // second multiplier stage, operands sign extended only for MULH
  assign mul_a    = {(op_q == OP_MULH) && a_q[31], a_q};
  assign mul_b    = {(op_q == OP_MULH) && b_q[31], b_q};
  assign product  = mul_a * mul_b;
  assign mul_word = (op_q == OP_MUL) ? product[31:0] : product[63:32];

  // divider loads straight from the request on the transfer edge
  radix2_divider #(
    .DIV_STEPS(DIV_STEPS)
  ) u_divider (
    .core_clock_i(core_clock_i),
    .rst_i       (rst_i),
    .core_flush_i(core_flush_i),
    .start_i     (req_fire && req_is_div),
    .signed_i    ((req_i.op == OP_DIV) || (req_i.op == OP_REM)),
    .rem_i       ((req_i.op == OP_REM) || (req_i.op == OP_REMU)),
    .a_i         (req_i.a),
    .b_i         (req_i.b),
    .done_o      (div_done),
    .res_o       (div_res)
  );

  always_ff @(posedge core_clock_i) begin
    if (rst_i || core_flush_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_fire) state_q <= req_is_div ? DIVIDE : MULTIPLY;
        end
        MULTIPLY: state_q <= HOLD;
        DIVIDE: begin
          if (div_done) state_q <= HOLD;
        end
        HOLD: begin
          if (req_fire) state_q <= req_is_div ? DIVIDE : MULTIPLY;
          else if (res_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (req_fire) begin
      op_q      <= req_i.op;
      a_q       <= req_i.a;
      b_q       <= req_i.b;
      rd_q      <= req_i.rd;
      rob_tag_q <= req_i.rob_tag;
    end
    if (state_q == MULTIPLY) begin
      data_q <= mul_word;
    end else if ((state_q == DIVIDE) && div_done) begin
      data_q <= div_res;
    end
  end

  assign res_valid_o = (state_q == HOLD);
  assign res_o       = '{rd: rd_q, data: data_q, rob_tag: rob_tag_q};

endmodule

`default_nettype wire

/* verilog/ixu_pipe_pkg.sv */
`default_nettype none

package ixu_pipe_pkg;
  import ixu_isa_pkg::*;

  typedef logic [31:0] xlen_data_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  rob_tag_t;

  // micro-op as it comes from issue, operands still as register numbers
  typedef struct packed {
    ixu_op_class_t op_class;
    ixu_op_t       op;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    logic          use_imm;
    xlen_data_t    imm;
    rob_tag_t      rob_tag;
  } ixu_issue_t;

  // operands already read, b is the immediate when use_imm was set
  typedef struct packed {
    ixu_op_t    op;
    xlen_data_t a;
    xlen_data_t b;
    reg_idx_t   rd;
    rob_tag_t   rob_tag;
  } ixu_exec_t;

  // one completion, also the register file write
  typedef struct packed {
    reg_idx_t   rd;
    xlen_data_t data;
    rob_tag_t   rob_tag;
  } ixu_result_t;

endpackage

`default_nettype wire

/* verilog/radix2_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module radix2_divider
  import ixu_pipe_pkg::*;
#(
  parameter int DIV_STEPS = 32
) (
  input  wire             core_clock_i,
  input  wire             rst_i,
  input  wire             core_flush_i,
  input  wire             start_i,
  input  wire             signed_i,
  input  wire             rem_i,
  input  wire xlen_data_t a_i,
  input  wire xlen_data_t b_i,
  output logic            done_o,
  output xlen_data_t      res_o
);

  localparam int CNT_W = $clog2(DIV_STEPS + 1);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DIV_STEPS - 1);

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  xlen_data_t       part_rem_q;
  xlen_data_t       quo_q;
  xlen_data_t       dvsr_q;
  xlen_data_t       dvnd_q;
  logic             want_rem_q;
  logic             q_neg_q;
  logic             r_neg_q;
  logic             dbz_q;
  logic             ovf_q;
  xlen_data_t       a_mag;
  xlen_data_t       b_mag;
  logic [32:0]      shifted;
  logic [33:0]      diff;
  logic             take;
  xlen_data_t       step_rem;
  xlen_data_t       step_quo;

  assign a_mag = (signed_i && a_i[31]) ? -a_i : a_i;
  assign b_mag = (signed_i && b_i[31]) ? -b_i : b_i;

  // one restoring step, the last one is taken combinationally into res_o
  assign shifted  = {part_rem_q, quo_q[31]};
  assign diff     = {1'b0, shifted} - {2'b00, dvsr_q};
  assign take     = !diff[33];
  assign step_rem = take ? diff[31:0] : shifted[31:0];
  assign step_quo = {quo_q[30:0], take};

  assign done_o = busy_q && (cnt_q == LAST_STEP);

  always_comb begin
    if (dbz_q) res_o = want_rem_q ? dvnd_q : '1;
    else if (ovf_q) res_o = want_rem_q ? '0 : dvnd_q;
    else if (want_rem_q) res_o = r_neg_q ? -step_rem : step_rem;
    else res_o = q_neg_q ? -step_quo : step_quo;
  end

  always_ff @(posedge core_clock_i) begin
    if (rst_i || core_flush_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (done_o) busy_q <= 1'b0;
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (start_i) begin
      part_rem_q <= '0;
      quo_q      <= a_mag;
      dvsr_q     <= b_mag;
      dvnd_q     <= a_i;
      want_rem_q <= rem_i;
      // remainder takes the sign of the dividend
      q_neg_q    <= signed_i && (a_i[31] ^ b_i[31]);
      r_neg_q    <= signed_i && a_i[31];
      dbz_q      <= (b_i == '0);
      ovf_q      <= signed_i && (a_i == 32'h8000_0000) && (b_i == '1);
    end else if (busy_q) begin
      part_rem_q <= step_rem;
      quo_q      <= step_quo;
    end
  end

endmodule

`default_nettype wire

/* verilog/wb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
  import ixu_pipe_pkg::*;
(
  input  wire ixu_result_t mc_res_i,
  input  wire ixu_result_t alu_res_i,
  input  wire              mc_valid_i,
  input  wire              alu_valid_i,
  output logic             mc_ready_o,
  output logic             alu_ready_o,
  output ixu_result_t      cmp_o,
  output logic             cmp_valid_o,
  input  wire              cmp_ready_i,
  output logic             wr_en_o,
  output logic             clr_en_o,
  output reg_idx_t         clr_idx_o
);

  logic cmp_fire;

  // multi-cycle results go first so a long op is never starved by ALU traffic
  assign mc_ready_o  = cmp_ready_i;
  assign alu_ready_o = cmp_ready_i && !mc_valid_i;

  assign cmp_valid_o = mc_valid_i || alu_valid_i;
  assign cmp_o       = mc_valid_i ? mc_res_i : alu_res_i;

  // single transfer strobe for the register file and the scoreboard
  assign cmp_fire = cmp_valid_o && cmp_ready_i;

  // x0 results still complete, they just write nothing
  assign wr_en_o   = cmp_fire && (cmp_o.rd != '0);
  assign clr_en_o  = cmp_fire;
  assign clr_idx_o = cmp_o.rd;

endmodule

`default_nettype wire
